//--- all.f
+incdir+.
serializer_pkg.sv
ready_list.sv
running_hints.sv
task_dispatcher.sv
serializer_csr.sv
serializer_top.sv
tb_clock_gen.sv
tb_serializer.sv

//--- ready_list.sv
`timescale 1ns/1ps
`include "serializer_macros.svh"

module ready_list (
   input  logic clk,
   input  logic rstn,
   input  serializer_pkg::enq_t enq,
   input  logic enq_conflict,
   input  serializer_pkg::hint_t fin_hint,
   input  logic fin_hint_valid,
   input  logic rm_valid,
   input  logic [`SER_LOG_DEPTH-1:0] rm_index,
   input  logic [`SER_LOG_DEPTH:0] thresh,
   output logic enq_ready,
   output serializer_pkg::hint_t new_hint,
   output serializer_pkg::list_view_t view,
   output serializer_pkg::task_t [`SER_LIST_DEPTH-1:0] entries,
   output logic [`SER_LOG_DEPTH:0] occupancy,
   output logic almost_full,
   output logic list_empty
);
   import serializer_pkg::*;

   localparam int DEPTH = `SER_LIST_DEPTH;
   localparam int OCC_W = `SER_LOG_DEPTH + 1;

   logic [DEPTH-1:0] valid_q;
   logic [DEPTH-1:0] conflict_q;
   logic [DEPTH-1:0] valid_d;
   logic [DEPTH-1:0] conflict_d;
   task_t [DEPTH-1:0] entry_d;

   // list contents as seen from one slot higher, used when shifting down
   logic [DEPTH-1:0] valid_up;
   logic [DEPTH-1:0] conflict_up;
   task_t [DEPTH-1:0] entry_up;

   task_t new_task;
   logic enq_fire;
   logic new_conflict;
   logic [DEPTH-1:0] list_match;
   logic [DEPTH-1:0] fin_hit;
   logic [DEPTH-1:0] fin_clr;
   logic [OCC_W-1:0] ins_loc;

   // the read-only bit must not split otherwise equal hints
   always_comb begin
      new_task = enq.tsk;
      new_task.hint[`SER_HINT_WIDTH-1] = 1'b0;
   end
   assign new_hint = new_task.hint;

   // a slot frees up this cycle if the dispatcher pulls an entry
   assign enq_ready = (occupancy != OCC_W'(DEPTH)) || rm_valid;
   assign enq_fire = enq.valid && enq_ready;

   for (genvar j = 0; j < DEPTH; j++) begin : g_match
      assign list_match[j] = valid_q[j] && (entries[j].hint == new_hint);
      assign fin_hit[j] = fin_hint_valid && valid_q[j] && (entries[j].hint == fin_hint);
      assign view.ttype[j] = entries[j].ttype;
   end

   // only the oldest waiter on the finishing hint is released
   assign fin_clr = fin_hit & (~fin_hit + 1'b1);

   assign new_conflict = enq_conflict || (list_match != '0);

   // tail moves down by one when an entry is removed in the same cycle
   assign ins_loc = rm_valid ? occupancy - 1'b1 : occupancy;

   assign valid_up = {1'b0, valid_q[DEPTH-1:1]};
   assign conflict_up = {1'b0, conflict_q[DEPTH-1:1] & ~fin_clr[DEPTH-1:1]};
   assign entry_up = {entries[DEPTH-1], entries[DEPTH-1:1]};

   always_comb begin
      valid_d = valid_q;
      conflict_d = conflict_q & ~fin_clr;
      entry_d = entries;
      for (int i = 0; i < DEPTH; i++) begin
         if (rm_valid && (i >= rm_index)) begin
            valid_d[i] = valid_up[i];
            conflict_d[i] = conflict_up[i];
            entry_d[i] = entry_up[i];
         end
         // new task goes in behind whatever survived the shift
         if (enq_fire && (i == ins_loc)) begin
            valid_d[i] = 1'b1;
            conflict_d[i] = new_conflict;
            entry_d[i] = new_task;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         valid_q <= '0;
         conflict_q <= '0;
         occupancy <= '0;
      end else begin
         valid_q <= valid_d;
         conflict_q <= conflict_d;
         occupancy <= occupancy + OCC_W'(enq_fire) - OCC_W'(rm_valid);
      end
   end

   always_ff @(posedge clk) begin
      entries <= entry_d;
   end

   assign view.valid = valid_q;
   assign view.conflict = conflict_q;

   assign almost_full = (occupancy >= thresh);
   assign list_empty = (occupancy == '0);

   // the count never runs past the list and always agrees with the valid bits
   a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
      enq_fire |=> (occupancy <= OCC_W'(DEPTH)) && ($countones(valid_q) == occupancy));

   // dispatcher only pulls live, released entries
   a_rm_legal: assert property (@(posedge clk) disable iff (!rstn)
      rm_valid |-> valid_q[rm_index] && !conflict_q[rm_index]);

endmodule

//--- run.sh
#!/bin/sh
# build the serializer testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_serializer -f all.f \
   -o tb_serializer > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_serializer > sim.log 2>&1
grep -q "Verification failed" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "Verification passed" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation ok"

//--- running_hints.sv
`timescale 1ns/1ps
`include "serializer_macros.svh"

module running_hints (
   input  logic clk,
   input  logic rstn,
   input  serializer_pkg::grant_t grant,
   input  serializer_pkg::finish_t fin,
   input  serializer_pkg::hint_t new_hint,
   output logic enq_conflict,
   output serializer_pkg::hint_t fin_hint,
   output logic fin_hint_valid,
   output logic cores_idle
);
   import serializer_pkg::*;

   localparam int NCORES = `SER_NUM_CORES;

   hint_t [NCORES-1:0] run_hint;
   logic [NCORES-1:0] run_valid;

   // grant in flight already counts as running on its core
   hint_t [NCORES-1:0] eff_hint;
   logic [NCORES-1:0] eff_valid;
   logic [NCORES-1:0] run_match;

   for (genvar c = 0; c < NCORES; c++) begin : g_core
      logic granted;
      logic finishing;

      assign granted = grant.valid && (grant.core == c);
      assign finishing = fin.valid && (fin.core == c);

      assign eff_valid[c] = run_valid[c] || granted;
      assign eff_hint[c] = granted ? grant.tsk.hint : run_hint[c];

      // a hint leaving this cycle does not block the new task
      assign run_match[c] = eff_valid[c] && (eff_hint[c] == new_hint) && !finishing;

      always_ff @(posedge clk) begin
         if (!rstn) begin
            run_valid[c] <= 1'b0;
         end else if (finishing) begin
            run_valid[c] <= 1'b0;
         end else if (granted) begin
            run_valid[c] <= 1'b1;
         end
         if (granted) begin
            run_hint[c] <= grant.tsk.hint;
         end
      end
   end

   assign enq_conflict = (run_match != '0);

   assign fin_hint = eff_hint[fin.core];
   assign fin_hint_valid = fin.valid && eff_valid[fin.core];

   assign cores_idle = (eff_valid == '0);

   // cores only report completion of a task they were handed
   a_fin_running: assert property (@(posedge clk) disable iff (!rstn)
      fin.valid |-> eff_valid[fin.core]);

endmodule

//--- serializer_csr.sv
`timescale 1ns/1ps
`include "serializer_macros.svh"

module serializer_csr (
   input  logic clk,
   input  logic rstn,
   input  logic [`SER_LOG_DEPTH:0] occupancy,
   input  serializer_pkg::list_view_t view,
   // write address and data
   input  logic awvalid,
   output logic awready,
   input  logic [7:0] awaddr,
   input  logic wvalid,
   output logic wready,
   input  logic [31:0] wdata,
   // write response
   output logic bvalid,
   input  logic bready,
   output logic [1:0] bresp,
   // read address and data
   input  logic arvalid,
   output logic arready,
   input  logic [7:0] araddr,
   output logic rvalid,
   input  logic rready,
   output logic [31:0] rdata,
   output logic [1:0] rresp,
   output logic [`SER_LOG_DEPTH:0] thresh
);
   import serializer_pkg::*;

   localparam int OCC_W = `SER_LOG_DEPTH + 1;
   localparam logic [OCC_W-1:0] THRESH_RESET = OCC_W'(4);

   logic wr_take;
   logic rd_take;

   // address and data only accepted as a pair, one write outstanding
   assign wr_take = awvalid && wvalid && !bvalid;
   assign awready = wr_take;
   assign wready = wr_take;

   assign arready = !rvalid;
   assign rd_take = arvalid && arready;

   assign bresp = 2'b00;
   assign rresp = 2'b00;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         bvalid <= 1'b0;
         thresh <= THRESH_RESET;
      end else begin
         if (wr_take) begin
            bvalid <= 1'b1;
            // status registers silently drop writes
            if (csr_addr_e'(awaddr) == CSR_THRESH) begin
               thresh <= wdata[OCC_W-1:0];
            end
         end else if (bready) begin
            bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rvalid <= 1'b0;
      end else if (rd_take) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_take) begin
         case (csr_addr_e'(araddr))
            CSR_THRESH:    rdata <= 32'(thresh);
            CSR_OCCUPANCY: rdata <= 32'(occupancy);
            CSR_LIST_MAP:  rdata <= 32'({view.valid, view.conflict});
            default:       rdata <= '0;
         endcase
      end
   end

endmodule

//--- serializer_macros.svh
`ifndef SERIALIZER_MACROS_SVH
`define SERIALIZER_MACROS_SVH

// cores that request work from the serializer
`define SER_NUM_CORES 4

// pending task slots and the index width into them
`define SER_LIST_DEPTH 8
`define SER_LOG_DEPTH 3

// task payload widths
`define SER_HINT_WIDTH 16
`define SER_ARG_WIDTH 16

// core id field, log2 of the core count
`define SER_CORE_ID_WIDTH 2

`endif

//--- serializer_pkg.sv
`include "serializer_macros.svh"

package serializer_pkg;

   typedef logic [`SER_HINT_WIDTH-1:0] hint_t;
   typedef logic [`SER_ARG_WIDTH-1:0] arg_t;
   typedef logic [`SER_CORE_ID_WIDTH-1:0] core_id_t;

   // TT_ANY only shows up in requests and matches every stored type
   typedef enum logic [1:0] {
      TT_A   = 2'd0,
      TT_B   = 2'd1,
      TT_C   = 2'd2,
      TT_ANY = 2'd3
   } ttype_e;

   typedef struct packed {
      ttype_e ttype;
      hint_t  hint;
      arg_t   arg;
   } task_t;

   typedef struct packed {
      logic  valid;
      task_t tsk;
   } enq_t;

   typedef struct packed {
      logic     valid;
      core_id_t core;
   } finish_t;

   typedef struct packed {
      logic     valid;
      core_id_t core;
      task_t    tsk;
   } grant_t;

   typedef struct packed {
      logic [`SER_NUM_CORES-1:0] valid;
      ttype_e [`SER_NUM_CORES-1:0] ttype;
   } req_t;

   typedef struct packed {
      logic [`SER_LIST_DEPTH-1:0] valid;
      logic [`SER_LIST_DEPTH-1:0] conflict;
      ttype_e [`SER_LIST_DEPTH-1:0] ttype;
   } list_view_t;

   typedef enum logic [7:0] {
      CSR_THRESH    = 8'h00,
      CSR_OCCUPANCY = 8'h04,
      CSR_LIST_MAP  = 8'h08
   } csr_addr_e;

endpackage

//--- serializer_top.sv
`timescale 1ns/1ps
`include "serializer_macros.svh"

module serializer_top (
   input  logic clk,
   input  logic rstn,
   input  serializer_pkg::enq_t enq,
   output logic enq_ready,
   input  serializer_pkg::req_t req,
   output serializer_pkg::grant_t grant,
   input  serializer_pkg::finish_t fin,
   input  logic awvalid,
   output logic awready,
   input  logic [7:0] awaddr,
   input  logic wvalid,
   output logic wready,
   input  logic [31:0] wdata,
   output logic bvalid,
   input  logic bready,
   output logic [1:0] bresp,
   input  logic arvalid,
   output logic arready,
   input  logic [7:0] araddr,
   output logic rvalid,
   input  logic rready,
   output logic [31:0] rdata,
   output logic [1:0] rresp,
   output logic almost_full,
   output logic all_idle
);
   import serializer_pkg::*;

   logic enq_conflict, fin_hint_valid, rm_valid, list_empty, cores_idle;
   hint_t new_hint;
   hint_t fin_hint;
   logic [`SER_LOG_DEPTH-1:0] rm_index;
   logic [`SER_LOG_DEPTH:0] thresh;
   logic [`SER_LOG_DEPTH:0] occupancy;
   list_view_t view;
   task_t [`SER_LIST_DEPTH-1:0] entries;

   ready_list u_list (.*);
   running_hints u_hints (.*);
   task_dispatcher u_disp (.*);
   serializer_csr u_csr (.*);

   // nothing pending and nothing running
   assign all_idle = list_empty && cores_idle;

endmodule

//--- task_dispatcher.sv
`timescale 1ns/1ps
`include "serializer_macros.svh"

module task_dispatcher (
   input  logic clk,
   input  logic rstn,
   input  serializer_pkg::req_t req,
   input  serializer_pkg::list_view_t view,
   input  serializer_pkg::task_t [`SER_LIST_DEPTH-1:0] entries,
   output logic rm_valid,
   output logic [`SER_LOG_DEPTH-1:0] rm_index,
   output serializer_pkg::grant_t grant
);
   import serializer_pkg::*;

   localparam int NCORES = `SER_NUM_CORES;
   localparam int DEPTH = `SER_LIST_DEPTH;

   logic [NCORES-1:0][DEPTH-1:0] eligible;
   logic [NCORES-1:0] can_take;
   core_id_t sel_core;
   logic [`SER_LOG_DEPTH-1:0] sel_idx;

   // entry j can serve core c
   always_comb begin
      for (int c = 0; c < NCORES; c++) begin
         for (int j = 0; j < DEPTH; j++) begin
            eligible[c][j] = view.valid[j] && !view.conflict[j] &&
                             ((req.ttype[c] == TT_ANY) || (view.ttype[j] == req.ttype[c]));
         end
      end
   end

   // core still sees its request high while its grant is out, skip it
   for (genvar c = 0; c < NCORES; c++) begin : g_take
      assign can_take[c] = req.valid[c] && (eligible[c] != '0) &&
                           !(grant.valid && (grant.core == c));
   end

   // lowest index core wins
   always_comb begin
      sel_core = '0;
      for (int c = NCORES - 1; c >= 0; c--) begin
         if (can_take[c]) begin
            sel_core = core_id_t'(c);
         end
      end
   end

   // oldest eligible entry for the winner
   always_comb begin
      sel_idx = '0;
      for (int j = DEPTH - 1; j >= 0; j--) begin
         if (eligible[sel_core][j]) begin
            sel_idx = j[`SER_LOG_DEPTH-1:0];
         end
      end
   end

   assign rm_valid = (can_take != '0);
   assign rm_index = sel_idx;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         grant.valid <= 1'b0;
      end else begin
         grant.valid <= rm_valid;
      end
      grant.core <= sel_core;
      grant.tsk <= entries[sel_idx];
   end

   // back to back grants never go to the same core
   a_no_repeat: assert property (@(posedge clk) disable iff (!rstn)
      grant.valid |=> !(grant.valid && (grant.core == $past(grant.core))));

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD = 40,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rstn
);
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // reset released on a rising edge, seen by the synchronous flops one edge later
   initial begin
      rstn = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rstn <= 1'b1;
   end
endmodule

//--- tb_serializer.sv
`timescale 1ns/1ps
`include "serializer_macros.svh"

module tb_serializer;
   import serializer_pkg::*;

   localparam int NC = `SER_NUM_CORES;
   localparam int SETUP = 60;
   localparam int TRAFFIC = 1500;
   localparam int DRAIN = 600;

   logic clk, rstn, enq_ready, almost_full, all_idle;
   enq_t enq;
   req_t req;
   grant_t grant;
   finish_t fin;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [7:0] awaddr, araddr;
   logic [31:0] wdata, rdata;
   logic [1:0] bresp, rresp;

   // reference model of the list, the running hints and the cores
   task_t mq[$];
   logic mc[$];
   logic [NC-1:0] run_v;
   hint_t run_h [NC];
   logic [1:0] core_st [NC];
   grant_t pend;
   task_t new_tsk;
   logic [3:0] mthresh;
   logic exp_ready, new_conf, rd_pend;
   logic [31:0] exp_rd;
   string rd_name;
   int enq_cnt, gnt_cnt, sel_core, sel_idx, clr_idx, n;
   logic [15:0] lfsr;

   tb_clock_gen clk_gen (.clk(clk), .rstn(rstn));

   serializer_top dut (.*);

   // galois lfsr, one step per bit
   function automatic logic [15:0] rnd(input int nbits);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         $display("ERR %s expected %0h actual %0h", name, exp, act);
         $display("Verification failed");
         $fatal(1);
      end
   endtask

   // oldest released entry that the request of core c accepts
   function automatic int oldest(input int c);
      int idx;
      idx = -1;
      for (int j = mq.size() - 1; j >= 0; j--) begin
         if (!mc[j] && (req.ttype[c] == TT_ANY || req.ttype[c] == mq[j].ttype))
            idx = j;
      end
      return idx;
   endfunction

   function automatic logic [31:0] list_map();
      logic [31:0] m;
      m = '0;
      foreach (mq[j]) begin
         m[8 + j] = 1'b1;
         m[j] = mc[j];
      end
      return m;
   endfunction

   // checks outputs mid cycle and works out what the next edge does
   task automatic evaluate();
      @(negedge clk);
      if (pend.valid) begin
         check("grant", pend, grant);
      end else begin
         check("grant valid", 0, grant.valid);
      end
      if (grant.valid)
         gnt_cnt++;
      for (int c = 0; c < NC; c++) begin
         if (grant.valid && c != grant.core && run_v[c])
            check("hint running elsewhere", 0, run_h[c] == grant.tsk.hint);
      end
      if (rd_pend) begin
         check("rvalid", 1, rvalid);
         check(rd_name, exp_rd, rdata);
      end
      if (arvalid) begin
         check("arready", 1, arready);
         rd_name = (araddr == CSR_OCCUPANCY) ? "occupancy" : "list_map";
         exp_rd = (araddr == CSR_OCCUPANCY) ? 32'(mq.size()) : list_map();
      end
      // lowest core with an eligible entry, skipping the one whose grant is out
      sel_core = -1;
      for (int c = NC - 1; c >= 0; c--) begin
         if (req.valid[c] && !(pend.valid && pend.core == c) && oldest(c) >= 0)
            sel_core = c;
      end
      sel_idx = (sel_core >= 0) ? oldest(sel_core) : -1;
      exp_ready = (mq.size() < `SER_LIST_DEPTH) || (sel_core >= 0);
      check("enq_ready", exp_ready, enq_ready);
      if (enq.valid && enq_ready)
         enq_cnt++;
      check("all_idle", (mq.size() == 0) && (run_v == 0), all_idle);
      check("almost_full", mq.size() >= mthresh, almost_full);
      new_tsk = enq.tsk;
      new_tsk.hint[`SER_HINT_WIDTH-1] = 1'b0;
      new_conf = 1'b0;
      clr_idx = -1;
      for (int j = mq.size() - 1; j >= 0; j--) begin
         if (mq[j].hint == new_tsk.hint)
            new_conf = 1'b1;
         if (fin.valid && mq[j].hint == run_h[fin.core])
            clr_idx = j;
      end
      for (int c = 0; c < NC; c++) begin
         if (run_v[c] && run_h[c] == new_tsk.hint && !(fin.valid && fin.core == c))
            new_conf = 1'b1;
      end
   endtask

   // updates the model at the rising edge and drives the next inputs
   task automatic advance(input bit traffic, input int cyc);
      enq_t nenq;
      req_t nreq;
      finish_t nfin;
      int c;
      @(posedge clk);
      if (clr_idx >= 0)
         mc[clr_idx] = 1'b0;
      if (fin.valid) begin
         run_v[fin.core] = 1'b0;
         core_st[fin.core] = 2'd0;
      end
      // core saw its grant pulse, it runs from now on
      if (pend.valid)
         core_st[pend.core] = 2'd2;
      pend.valid = 1'b0;
      if (sel_core >= 0) begin
         pend = {1'b1, core_id_t'(sel_core), mq[sel_idx]};
         run_v[sel_core] = 1'b1;
         run_h[sel_core] = mq[sel_idx].hint;
         mq.delete(sel_idx);
         mc.delete(sel_idx);
      end
      if (enq.valid && exp_ready) begin
         mq.push_back(new_tsk);
         mc.push_back(new_conf);
      end
      // last core always asks for any type so the list keeps moving
      nreq = req;
      for (c = 0; c < NC; c++) begin
         if (core_st[c] == 2'd0 && (!traffic || rnd(1) != 0)) begin
            core_st[c] = 2'd1;
            nreq.valid[c] = 1'b1;
            nreq.ttype[c] = (c == NC - 1 || !traffic) ? TT_ANY : ttype_e'(2'(rnd(2)));
         end else if (core_st[c] != 2'd1) begin
            nreq.valid[c] = 1'b0;
         end
      end
      nfin = '0;
      c = int'(rnd(2));
      if (core_st[c] == 2'd2 && (!traffic || rnd(2) == 0)) begin
         nfin.valid = 1'b1;
         nfin.core = core_id_t'(c);
      end
      // an offer that was not taken stays on the bus
      nenq = enq;
      if (!enq.valid || exp_ready) begin
         nenq.valid = traffic && (rnd(2) != 0);
         nenq.tsk.ttype = ttype_e'(2'(rnd(2) % 3));
         nenq.tsk.hint = {1'(rnd(1)), 12'h0a5, 3'(rnd(3))};
         nenq.tsk.arg = rnd(16);
      end
      rd_pend = arvalid;
      enq <= nenq;
      req <= nreq;
      fin <= nfin;
      if (traffic && cyc % 8 == 0) begin
         arvalid <= 1'b1;
         araddr <= (cyc % 16 == 0) ? CSR_LIST_MAP : CSR_OCCUPANCY;
      end else begin
         arvalid <= 1'b0;
      end
   endtask

   task automatic csr_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      awvalid <= 1'b1;
      wvalid <= 1'b1;
      awaddr <= addr;
      wdata <= data;
      @(negedge clk);
      while (!(awready && wready))
         @(negedge clk);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid <= 1'b0;
      @(negedge clk);
      while (!bvalid)
         @(negedge clk);
      check("bresp", 0, bresp);
   endtask

   task automatic csr_read(input logic [7:0] addr, input logic [31:0] exp, input string name);
      @(posedge clk);
      arvalid <= 1'b1;
      araddr <= addr;
      @(negedge clk);
      while (!arready)
         @(negedge clk);
      @(posedge clk);
      arvalid <= 1'b0;
      @(negedge clk);
      while (!rvalid)
         @(negedge clk);
      check("rresp", 0, rresp);
      check(name, exp, rdata);
   endtask

   initial begin
      lfsr = 16'd16;
      enq = '0;
      req = '0;
      fin = '0;
      {awvalid, wvalid, arvalid, awaddr, araddr, wdata} = '0;
      bready = 1'b1;
      rready = 1'b1;
      run_v = '0;
      core_st = '{default: 2'd0};
      pend = '0;
      mthresh = 4'd4;
      {exp_ready, new_conf, rd_pend} = '0;
      {enq_cnt, gnt_cnt} = '0;
      sel_core = -1;
      clr_idx = -1;
      @(posedge rstn);
      @(negedge clk);
      check("idle after reset", 1, all_idle);
      check("valids after reset", 0, {grant.valid, bvalid, rvalid});
      csr_read(CSR_THRESH, 4, "thresh after reset");
      mthresh = 4'(rnd(3)) + 4'd2;
      csr_write(CSR_THRESH, 32'(mthresh));
      csr_read(CSR_THRESH, 32'(mthresh), "thresh");
      // a value that differs from the threshold, so a misdecoded write shows up
      csr_write(CSR_OCCUPANCY, {28'h0, ~mthresh});
      csr_read(CSR_OCCUPANCY, 0, "occupancy write ignored");
      csr_read(CSR_THRESH, 32'(mthresh), "thresh after occupancy write");
      for (int i = 0; i < TRAFFIC; i++) begin
         evaluate();
         advance(1'b1, i);
      end
      // no new tasks, idle cores take anything left
      n = 0;
      while ((mq.size() != 0 || run_v != 0) && n < DRAIN) begin
         evaluate();
         advance(1'b0, n);
         n++;
      end
      if (n == DRAIN) begin
         $display("list and cores did not drain within %0d cycles", DRAIN);
         $display("Verification failed");
         $fatal(1);
      end else begin
         evaluate();
         csr_read(CSR_OCCUPANCY, 0, "occupancy drained");
         check("tasks accounted", enq_cnt, gnt_cnt + mq.size());
         check("idle after drain", 1, all_idle);
         $display("Verification passed");
         $finish;
      end
   end

   initial begin
      #((SETUP + TRAFFIC + DRAIN + 100) * 40);
      $display("watchdog expired before the test sequence completed");
      $display("Verification failed");
      $fatal(1);
   end
endmodule
